//--- sa_consts.svh
`ifndef SA_CONSTS_SVH
`define SA_CONSTS_SVH

// Array geometry
`define SA_R 4
`define SA_C 4

// Element widths
`define SA_WX 8
`define SA_WK 8
`define SA_WY 32
`define SA_WA 32

// One memory beat
`define MEM_WIDTH 64

`endif

//--- sa_pkg.sv
`include "sa_consts.svh"

package sa_pkg;

  // Scalar elements
  typedef logic signed [`SA_WX-1:0] x_t;
  typedef logic signed [`SA_WK-1:0] k_t;
  typedef logic signed [`SA_WY-1:0] acc_t;
  typedef logic signed [`SA_WA-1:0] psum_t;

  // Element 0 sits in the low bits
  typedef x_t [`SA_R-1:0] x_vec_t;
  typedef k_t [`SA_C-1:0] k_vec_t;

  // One drained column of results, and its matching partial sums
  typedef acc_t  [`SA_R-1:0] col_t;
  typedef psum_t [`SA_R-1:0] psum_col_t;

endpackage

//--- mem_pkg.sv
`include "sa_consts.svh"

package mem_pkg;

  // One full beat on the memory side
  typedef logic [`MEM_WIDTH-1:0] mem_word_t;

endpackage

//--- sa_pe.sv
`timescale 1ns/1ps

module sa_pe (
  input  logic         clk,
  input  logic         rst,
  input  sa_pkg::x_t   x,
  input  sa_pkg::k_t   k,
  input  logic         step,
  input  logic         close,
  output sa_pkg::acc_t result
);
  import sa_pkg::*;

  acc_t acc;
  acc_t prod;
  acc_t sum;

  assign prod = acc_t'(x) * acc_t'(k);

  // Includes the product of the beat that closes the packet
  assign sum = step ? acc + prod : acc;

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (close) begin
      acc <= '0;
    end else if (step) begin
      acc <= sum;
    end
  end

  // Shadow copy stays readable while the next packet accumulates
  always_ff @(posedge clk) begin
    if (close) begin
      result <= sum;
    end
  end

endmodule

//--- sa_array.sv
`timescale 1ns/1ps

`include "sa_consts.svh"

module sa_array (
  input  logic             clk,
  input  logic             rst,
  input  sa_pkg::k_vec_t   k_data,
  input  logic             k_valid,
  input  logic             k_last,
  output logic             k_ready,
  input  sa_pkg::x_vec_t   x_data,
  input  logic             x_valid,
  input  logic             x_last,
  output logic             x_ready,
  output sa_pkg::col_t     out_data,
  output logic             out_valid,
  output logic             out_last,
  input  logic             out_ready
);
  import sa_pkg::*;

  localparam int COL_W = $clog2(`SA_C);
  localparam logic [COL_W-1:0] COL_MAX = COL_W'(`SA_C - 1);

  logic in_valid;
  logic in_last;
  logic in_ready;
  logic in_fire;
  logic in_close;

  logic             out_fire;
  logic             col_end;
  logic [COL_W-1:0] col;

  acc_t pe_res [`SA_C][`SA_R];

  // Join of the weight and pixel streams
  assign in_valid = k_valid & x_valid;
  assign in_last  = k_last & x_last;
  assign k_ready  = in_ready & x_valid;
  assign x_ready  = in_ready & k_valid;

  assign out_fire = out_valid & out_ready;
  assign col_end  = (col == COL_MAX);

  // Stall a closing beat only while the shadow bank still has columns to go
  assign in_ready = ~(in_last & out_valid & ~(out_ready & col_end));

  assign in_fire  = in_valid & in_ready;
  assign in_close = in_fire & in_last;

  for (genvar c = 0; c < `SA_C; c++) begin : g_col
    for (genvar r = 0; r < `SA_R; r++) begin : g_row
      sa_pe pe (
        .clk    (clk),
        .rst    (rst),
        .x      (x_data[r]),
        .k      (k_data[c]),
        .step   (in_fire),
        .close  (in_close),
        .result (pe_res[c][r])
      );
    end
  end

  // Drains one column per out handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      col       <= '0;
    end else if (in_close) begin
      out_valid <= 1'b1;
      col       <= '0;
    end else if (out_fire) begin
      if (col_end) begin
        out_valid <= 1'b0;
        col       <= '0;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  assign out_last = col_end;

  always_comb begin
    for (int r = 0; r < `SA_R; r++) begin
      out_data[r] = pe_res[col][r];
    end
  end

endmodule

//--- psum_add.sv
`timescale 1ns/1ps

module psum_add (
  input  logic              clk,
  input  logic              rst,
  input  sa_pkg::col_t      arr_data,
  input  logic              arr_valid,
  input  logic              arr_last,
  output logic              arr_ready,
  input  sa_pkg::psum_col_t psum_data,
  input  logic              psum_valid,
  input  logic              psum_last,
  output logic              psum_ready,
  output sa_pkg::col_t      out_data,
  output logic              out_valid,
  output logic              out_last,
  input  logic              out_ready
);
  import sa_pkg::*;

  localparam int ROWS = $size(col_t);

  logic space;
  logic load;

  // Output register free now or emptied this cycle
  assign space      = ~out_valid | out_ready;
  assign arr_ready  = space & psum_valid;
  assign psum_ready = space & arr_valid;
  assign load       = space & arr_valid & psum_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
      out_last  <= arr_last & psum_last;
    end else if (out_ready) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end
  end

  // Two's complement sums wrap at the result width
  always_ff @(posedge clk) begin
    if (load) begin
      for (int r = 0; r < ROWS; r++) begin
        out_data[r] <= arr_data[r] + acc_t'(psum_data[r]);
      end
    end
  end

endmodule

//--- stream_unpack.sv
`timescale 1ns/1ps

module stream_unpack #(
  parameter type wide_t   = logic [63:0],
  parameter type narrow_t = logic [31:0]
) (
  input  logic    clk,
  input  logic    rst,
  input  wide_t   in_data,
  input  logic    in_valid,
  input  logic    in_last,
  output logic    in_ready,
  output narrow_t out_data,
  output logic    out_valid,
  output logic    out_last,
  input  logic    out_ready
);

  localparam int NW    = $bits(narrow_t);
  localparam int RATIO = $bits(wide_t) / NW;
  localparam int CNT_W = $clog2(RATIO);

  logic [$bits(wide_t)-1:0] hold;
  logic                     hold_last;
  logic [CNT_W-1:0]         cnt;
  logic                     last_piece;
  logic                     in_fire;

  assign last_piece = (cnt == CNT_W'(RATIO - 1));
  assign in_ready   = ~out_valid | (out_ready & last_piece);
  assign in_fire    = in_valid & in_ready;

  // Low piece goes out first
  assign out_data = narrow_t'(hold[cnt*NW +: NW]);
  assign out_last = hold_last & last_piece;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      hold_last <= 1'b0;
      cnt       <= '0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
      hold_last <= in_last;
      cnt       <= '0;
    end else if (out_valid & out_ready) begin
      out_valid <= ~last_piece;
      cnt       <= last_piece ? '0 : cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      hold <= in_data;
    end
  end

endmodule

//--- stream_pack.sv
`timescale 1ns/1ps

module stream_pack #(
  parameter type wide_t   = logic [63:0],
  parameter type narrow_t = logic [31:0]
) (
  input  logic    clk,
  input  logic    rst,
  input  narrow_t in_data,
  input  logic    in_valid,
  input  logic    in_last,
  output logic    in_ready,
  output wide_t   out_data,
  output logic    out_valid,
  output logic    out_last,
  input  logic    out_ready
);

  localparam int NW    = $bits(narrow_t);
  localparam int RATIO = $bits(wide_t) / NW;
  localparam int CNT_W = $clog2(RATIO);

  logic [$bits(wide_t)-1:0] fill;
  logic [$bits(wide_t)-1:0] fill_next;
  logic [CNT_W-1:0]         cnt;
  logic                     in_fire;
  logic                     done;

  assign in_ready = ~out_valid | out_ready;
  assign in_fire  = in_valid & in_ready;
  assign done     = in_fire & (cnt == CNT_W'(RATIO - 1));

  // First piece lands in the low bits
  always_comb begin
    fill_next                = fill;
    fill_next[cnt*NW +: NW]  = in_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      cnt       <= '0;
    end else begin
      if (done) begin
        out_valid <= 1'b1;
        out_last  <= in_last;
      end else if (out_ready) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end
      if (in_fire) begin
        cnt <= done ? '0 : cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      fill <= fill_next;
    end
    if (done) begin
      out_data <= wide_t'(fill_next);
    end
  end

endmodule

//--- sa_top.sv
`timescale 1ns/1ps

module sa_top (
  input  logic              clk,
  input  logic              rst,
  input  mem_pkg::mem_word_t k_data,
  input  logic              k_valid,
  input  logic              k_last,
  output logic              k_ready,
  input  mem_pkg::mem_word_t x_data,
  input  logic              x_valid,
  input  logic              x_last,
  output logic              x_ready,
  input  mem_pkg::mem_word_t a_data,
  input  logic              a_valid,
  input  logic              a_last,
  output logic              a_ready,
  output mem_pkg::mem_word_t y_data,
  output logic              y_valid,
  output logic              y_last,
  input  logic              y_ready
);
  import sa_pkg::*;
  import mem_pkg::*;

  k_vec_t    kv_data;
  logic      kv_valid;
  logic      kv_last;
  logic      kv_ready;

  x_vec_t    xv_data;
  logic      xv_valid;
  logic      xv_last;
  logic      xv_ready;

  psum_col_t ps_data;
  logic      ps_valid;
  logic      ps_last;
  logic      ps_ready;

  col_t      arr_data;
  logic      arr_valid;
  logic      arr_last;
  logic      arr_ready;

  col_t      sum_data;
  logic      sum_valid;
  logic      sum_last;
  logic      sum_ready;

  // Memory words down to array vectors
  stream_unpack #(.wide_t(mem_word_t), .narrow_t(k_vec_t)) unpack_k (
    .clk       (clk),
    .rst       (rst),
    .in_data   (k_data),
    .in_valid  (k_valid),
    .in_last   (k_last),
    .in_ready  (k_ready),
    .out_data  (kv_data),
    .out_valid (kv_valid),
    .out_last  (kv_last),
    .out_ready (kv_ready)
  );

  stream_unpack #(.wide_t(mem_word_t), .narrow_t(x_vec_t)) unpack_x (
    .clk       (clk),
    .rst       (rst),
    .in_data   (x_data),
    .in_valid  (x_valid),
    .in_last   (x_last),
    .in_ready  (x_ready),
    .out_data  (xv_data),
    .out_valid (xv_valid),
    .out_last  (xv_last),
    .out_ready (xv_ready)
  );

  // Two words make one partial-sum column
  stream_pack #(.wide_t(psum_col_t), .narrow_t(mem_word_t)) pack_a (
    .clk       (clk),
    .rst       (rst),
    .in_data   (a_data),
    .in_valid  (a_valid),
    .in_last   (a_last),
    .in_ready  (a_ready),
    .out_data  (ps_data),
    .out_valid (ps_valid),
    .out_last  (ps_last),
    .out_ready (ps_ready)
  );

  sa_array array (
    .clk       (clk),
    .rst       (rst),
    .k_data    (kv_data),
    .k_valid   (kv_valid),
    .k_last    (kv_last),
    .k_ready   (kv_ready),
    .x_data    (xv_data),
    .x_valid   (xv_valid),
    .x_last    (xv_last),
    .x_ready   (xv_ready),
    .out_data  (arr_data),
    .out_valid (arr_valid),
    .out_last  (arr_last),
    .out_ready (arr_ready)
  );

  psum_add adder (
    .clk        (clk),
    .rst        (rst),
    .arr_data   (arr_data),
    .arr_valid  (arr_valid),
    .arr_last   (arr_last),
    .arr_ready  (arr_ready),
    .psum_data  (ps_data),
    .psum_valid (ps_valid),
    .psum_last  (ps_last),
    .psum_ready (ps_ready),
    .out_data   (sum_data),
    .out_valid  (sum_valid),
    .out_last   (sum_last),
    .out_ready  (sum_ready)
  );

  // Result columns back out as memory words, rows 0-1 first
  stream_unpack #(.wide_t(col_t), .narrow_t(mem_word_t)) unpack_y (
    .clk       (clk),
    .rst       (rst),
    .in_data   (sum_data),
    .in_valid  (sum_valid),
    .in_last   (sum_last),
    .in_ready  (sum_ready),
    .out_data  (y_data),
    .out_valid (y_valid),
    .out_last  (y_last),
    .out_ready (y_ready)
  );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

//--- tb_sa_top.sv
`timescale 1ns/1ps

`include "sa_consts.svh"

module tb_sa_top;
  import sa_pkg::*;
  import mem_pkg::*;

  localparam logic [31:0] SEED = 32'h52d904c2;
  // Five packets of 2*C words each
  localparam int Y_WORDS    = 5 * 2 * `SA_C;
  localparam int MAX_CYCLES = 20 * Y_WORDS + 200;

  logic      clk;
  logic      rst;
  mem_word_t k_data;
  logic      k_valid;
  logic      k_last;
  logic      k_ready;
  mem_word_t x_data;
  logic      x_valid;
  logic      x_last;
  logic      x_ready;
  mem_word_t a_data;
  logic      a_valid;
  logic      a_last;
  logic      a_ready;
  mem_word_t y_data;
  logic      y_valid;
  logic      y_last;
  logic      y_ready;

  logic [31:0] rng = SEED;
  int          cycles = 0;

  mem_word_t k_words[$];
  bit        k_lasts[$];
  mem_word_t x_words[$];
  bit        x_lasts[$];
  mem_word_t a_words[$];
  bit        a_lasts[$];
  mem_word_t exp_words[$];
  bit        exp_lasts[$];

  tb_clock #(.PERIOD(100)) clock_gen (.clk(clk));

  sa_top dut (
    .clk     (clk),
    .rst     (rst),
    .k_data  (k_data),
    .k_valid (k_valid),
    .k_last  (k_last),
    .k_ready (k_ready),
    .x_data  (x_data),
    .x_valid (x_valid),
    .x_last  (x_last),
    .x_ready (x_ready),
    .a_data  (a_data),
    .a_valid (a_valid),
    .a_last  (a_last),
    .a_ready (a_ready),
    .y_data  (y_data),
    .y_valid (y_valid),
    .y_last  (y_last),
    .y_ready (y_ready)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycles);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    rng = lcg(rng);
    return rng;
  endfunction

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("error: %s actual 0x%h expected 0x%h", name, act, exp);
      $display("TB FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic check_idle();
    check("y_valid", 64'(y_valid), 64'd0);
    check("k_ready", 64'(k_ready), 64'd1);
    check("x_ready", 64'(x_ready), 64'd1);
    check("a_ready", 64'(a_ready), 64'd1);
  endtask

  // Builds one packet's input words and its expected result words
  task automatic add_packet(input int n, input int mode);
    x_t          xs [8][`SA_R];
    k_t          ks [8][`SA_C];
    psum_t       as [`SA_C][`SA_R];
    acc_t        ys [`SA_C][`SA_R];
    logic [31:0] v;
    mem_word_t   kw;
    mem_word_t   xw;
    mem_word_t   aw;
    mem_word_t   yw;
    for (int i = 0; i < n; i++) begin
      for (int r = 0; r < `SA_R; r++) begin
        v = rand32();
        // Mode 1 forces negative pixels
        xs[i][r] = (mode == 1) ? {1'b1, v[6:0]} : v[7:0];
      end
      for (int c = 0; c < `SA_C; c++) begin
        v = rand32();
        ks[i][c] = v[7:0];
      end
    end
    for (int c = 0; c < `SA_C; c++) begin
      for (int r = 0; r < `SA_R; r++) begin
        v = rand32();
        if (mode == 0) begin
          as[c][r] = '0;
        end else if (mode == 1) begin
          as[c][r] = {v[0] ? 24'h7fffff : 24'h800000, v[15:8]};
        end else begin
          as[c][r] = v;
        end
        ys[c][r] = as[c][r];
        for (int i = 0; i < n; i++) begin
          ys[c][r] = ys[c][r] + xs[i][r] * ks[i][c];
        end
      end
    end
    // Two vectors per word, low half first
    for (int wi = 0; wi < n / 2; wi++) begin
      for (int h = 0; h < 2; h++) begin
        for (int e = 0; e < `SA_C; e++) begin
          kw[32*h + 8*e +: 8] = ks[2*wi + h][e];
        end
        for (int e = 0; e < `SA_R; e++) begin
          xw[32*h + 8*e +: 8] = xs[2*wi + h][e];
        end
      end
      k_words.push_back(kw);
      k_lasts.push_back(wi == n / 2 - 1);
      x_words.push_back(xw);
      x_lasts.push_back(wi == n / 2 - 1);
    end
    // Column c splits into rows 0-1 then rows 2-3
    for (int c = 0; c < `SA_C; c++) begin
      for (int h = 0; h < 2; h++) begin
        for (int j = 0; j < 2; j++) begin
          aw[32*j +: 32] = as[c][2*h + j];
          yw[32*j +: 32] = ys[c][2*h + j];
        end
        a_words.push_back(aw);
        a_lasts.push_back(c == `SA_C - 1 && h == 1);
        exp_words.push_back(yw);
        exp_lasts.push_back(c == `SA_C - 1 && h == 1);
      end
    end
  endtask

  task automatic drive_k(input bit gaps);
    logic [31:0] st;
    logic        taken;
    st = SEED ^ 32'h1;
    while (k_words.size() > 0) begin
      k_valid = 1'b0;
      if (gaps) begin
        st = lcg(st);
        repeat (st[31:30]) begin
          @(posedge clk);
          #1;
        end
      end
      k_valid = 1'b1;
      k_data  = k_words.pop_front();
      k_last  = k_lasts.pop_front();
      do begin
        @(negedge clk);
        taken = k_ready;
        @(posedge clk);
        #1;
      end while (!taken);
    end
    k_valid = 1'b0;
  endtask

  task automatic drive_x(input bit gaps);
    logic [31:0] st;
    logic        taken;
    st = SEED ^ 32'h2;
    while (x_words.size() > 0) begin
      x_valid = 1'b0;
      if (gaps) begin
        st = lcg(st);
        repeat (st[31:30]) begin
          @(posedge clk);
          #1;
        end
      end
      x_valid = 1'b1;
      x_data  = x_words.pop_front();
      x_last  = x_lasts.pop_front();
      do begin
        @(negedge clk);
        taken = x_ready;
        @(posedge clk);
        #1;
      end while (!taken);
    end
    x_valid = 1'b0;
  endtask

  task automatic drive_a();
    logic taken;
    while (a_words.size() > 0) begin
      a_valid = 1'b1;
      a_data  = a_words.pop_front();
      a_last  = a_lasts.pop_front();
      do begin
        @(negedge clk);
        taken = a_ready;
        @(posedge clk);
        #1;
      end while (!taken);
    end
    a_valid = 1'b0;
  endtask

  task automatic collect_y(input bit toggle);
    logic [31:0] st;
    mem_word_t   exp_word;
    bit          exp_last;
    st = SEED ^ 32'h4;
    while (exp_words.size() > 0) begin
      st = lcg(st);
      y_ready = toggle ? st[31] : 1'b1;
      @(negedge clk);
      if (y_valid && y_ready) begin
        exp_word = exp_words.pop_front();
        exp_last = exp_lasts.pop_front();
        check("y_data", y_data, exp_word);
        check("y_last", 64'(y_last), 64'(exp_last));
      end
      @(posedge clk);
      #1;
    end
    y_ready = 1'b1;
  endtask

  // Sends everything queued, then watches for stray output words
  task automatic run_traffic(input bit gaps, input bit toggle);
    fork
      drive_k(gaps);
      drive_x(gaps);
      drive_a();
      collect_y(toggle);
    join
    repeat (20) begin
      @(negedge clk);
      check("y_valid", 64'(y_valid), 64'd0);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_reset_idle();
    rst = 1'b1;
    repeat (10) begin
      @(posedge clk);
      #1;
      check_idle();
    end
    rst = 1'b0;
    repeat (10) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_single_packet();
    add_packet(4, 0);
    run_traffic(1'b0, 1'b0);
  endtask

  task automatic test_wraparound();
    add_packet(4, 1);
    run_traffic(1'b0, 1'b0);
  endtask

  task automatic test_y_backpressure();
    add_packet(4, 2);
    run_traffic(1'b0, 1'b1);
  endtask

  task automatic test_back_to_back();
    add_packet(2, 2);
    add_packet(6, 1);
    run_traffic(1'b1, 1'b0);
  endtask

  initial begin
    rst     = 1'b1;
    k_data  = '0;
    k_valid = 1'b0;
    k_last  = 1'b0;
    x_data  = '0;
    x_valid = 1'b0;
    x_last  = 1'b0;
    a_data  = '0;
    a_valid = 1'b0;
    a_last  = 1'b0;
    y_ready = 1'b1;
    test_reset_idle();
    test_single_packet();
    test_wraparound();
    test_y_backpressure();
    test_back_to_back();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+.
sa_pkg.sv
mem_pkg.sv
sa_pe.sv
sa_array.sv
psum_add.sv
stream_unpack.sv
stream_pack.sv
sa_top.sv
tb_clock.sv
tb_sa_top.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f src.f --top-module tb_sa_top -Mdir obj_dir -o tb_sa_top

run: compile
	./obj_dir/tb_sa_top | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
